// ==== noc_route_pkg.sv ====
`default_nettype none

package noc_route_pkg;

    localparam int coord_w = 3;             // up to 8 routers per dimension
    localparam int addr_w  = 2 * coord_w;   // {y, x}
    localparam int port_w  = 3;

    typedef logic [coord_w-1:0] coord_t;
    typedef logic [addr_w-1:0]  r_addr_t;   // y in the upper half

    // mesh port order, local first
    typedef enum logic [port_w-1:0] {
        port_local = 3'd0,
        port_east  = 3'd1,
        port_north = 3'd2,
        port_west  = 3'd3,
        port_south = 3'd4
    } port_e;

    // deterministic XY rule; x is resolved before y
    function automatic port_e xy_port(
        input coord_t cur_x,
        input coord_t cur_y,
        input coord_t dst_x,
        input coord_t dst_y
    );
        port_e p;
        if (dst_x != cur_x) begin
            p = (dst_x > cur_x) ? port_east : port_west;
        end else if (dst_y != cur_y) begin
            p = (dst_y > cur_y) ? port_south : port_north;  // north lowers y
        end else begin
            p = port_local;
        end
        return p;
    endfunction

    // true when b turns straight back along a
    function automatic logic is_reverse(
        input port_e a,
        input port_e b
    );
        logic r;
        case (a)
            port_east:  r = (b == port_west);
            port_west:  r = (b == port_east);
            port_north: r = (b == port_south);
            port_south: r = (b == port_north);
            default:    r = 1'b0;
        endcase
        return r;
    endfunction

endpackage

`default_nettype wire

// ==== route_coord_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// decoded router coordinates, shared between the address
// decoder and the XY execute stage
interface route_coord_if;

    noc_route_pkg::coord_t cur_x;   // current router column
    noc_route_pkg::coord_t cur_y;   // current router row
    noc_route_pkg::coord_t dst_x;   // destination column
    noc_route_pkg::coord_t dst_y;   // destination row

    modport decode (
        output cur_x,
        output cur_y,
        output dst_x,
        output dst_y
    );

    modport execute (
        input cur_x,
        input cur_y,
        input dst_x,
        input dst_y
    );

endinterface

`default_nettype wire

// ==== route_addr_decode.sv ====
`timescale 1ns/100ps
`default_nettype none

module route_addr_decode #(
    parameter int NX = 4,
    parameter int NY = 4
) (
    input  noc_route_pkg::r_addr_t current_r_addr,
    input  noc_route_pkg::r_addr_t dest_e_addr,
    route_coord_if.decode          coord,
    output logic                   addr_ok
);

    localparam int cw = noc_route_pkg::coord_w;
    localparam int aw = noc_route_pkg::addr_w;

    noc_route_pkg::coord_t cur_x;
    noc_route_pkg::coord_t cur_y;
    noc_route_pkg::coord_t dst_x;
    noc_route_pkg::coord_t dst_y;

    logic cur_in_mesh;
    logic dst_in_mesh;

    // row in the high half, column in the low half
    assign cur_x = current_r_addr[cw-1:0];
    assign cur_y = current_r_addr[aw-1:cw];

    // one endpoint per router, so the endpoint address is a router address
    assign dst_x = dest_e_addr[cw-1:0];
    assign dst_y = dest_e_addr[aw-1:cw];

    assign coord.cur_x = cur_x;
    assign coord.cur_y = cur_y;
    assign coord.dst_x = dst_x;
    assign coord.dst_y = dst_y;

    // field width allows 8, mesh may be smaller
    assign cur_in_mesh = (int'(cur_x) < NX) && (int'(cur_y) < NY);
    assign dst_in_mesh = (int'(dst_x) < NX) && (int'(dst_y) < NY);

    assign addr_ok = cur_in_mesh && dst_in_mesh;

endmodule

`default_nettype wire

// ==== xy_route_execute.sv ====
`timescale 1ns/100ps
`default_nettype none

module xy_route_execute (
    route_coord_if.execute          coord,
    output noc_route_pkg::port_e    destport_c,
    output noc_route_pkg::port_e    lkdestport_c,
    output noc_route_pkg::r_addr_t  next_r_addr_c
);

    noc_route_pkg::coord_t nxt_x;
    noc_route_pkg::coord_t nxt_y;

    // conventional port at this router
    always_comb begin
        destport_c = noc_route_pkg::xy_port(
            coord.cur_x,
            coord.cur_y,
            coord.dst_x,
            coord.dst_y
        );
    end

    // one hop in the chosen direction
    always_comb begin
        nxt_x = coord.cur_x;
        nxt_y = coord.cur_y;
        case (destport_c)
            noc_route_pkg::port_east: begin
                nxt_x = coord.cur_x + noc_route_pkg::coord_t'(1);
            end
            noc_route_pkg::port_west: begin
                nxt_x = coord.cur_x - noc_route_pkg::coord_t'(1);
            end
            noc_route_pkg::port_north: begin
                nxt_y = coord.cur_y - noc_route_pkg::coord_t'(1);  // north is y-1
            end
            noc_route_pkg::port_south: begin
                nxt_y = coord.cur_y + noc_route_pkg::coord_t'(1);
            end
            default: begin
                nxt_x = coord.cur_x;   // local, flit stays here
                nxt_y = coord.cur_y;
            end
        endcase
    end

    assign next_r_addr_c = {nxt_y, nxt_x};

    // look-ahead: same rule evaluated from the neighbor
    always_comb begin
        lkdestport_c = noc_route_pkg::xy_port(
            nxt_x,
            nxt_y,
            coord.dst_x,
            coord.dst_y
        );
    end

endmodule

`default_nettype wire

// ==== route_result_reg.sv ====
`timescale 1ns/100ps
`default_nettype none

module route_result_reg #(
    parameter int NX = 4,
    parameter int NY = 4
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    hdr_valid,
    input  logic                    addr_ok,
    input  noc_route_pkg::port_e    destport_c,
    input  noc_route_pkg::port_e    lkdestport_c,
    input  noc_route_pkg::r_addr_t  next_r_addr_c,
    output logic                    route_valid,
    output logic                    addr_error,
    output noc_route_pkg::port_e    destport,
    output noc_route_pkg::port_e    lkdestport,
    output noc_route_pkg::r_addr_t  next_r_addr
);

    localparam int cw = noc_route_pkg::coord_w;
    localparam int aw = noc_route_pkg::addr_w;

    noc_route_pkg::r_addr_t here_addr;

    // undo the hop to recover the current router address
    always_comb begin
        noc_route_pkg::coord_t x;
        noc_route_pkg::coord_t y;
        x = next_r_addr_c[cw-1:0];
        y = next_r_addr_c[aw-1:cw];
        case (destport_c)
            noc_route_pkg::port_east:  x = x - noc_route_pkg::coord_t'(1);
            noc_route_pkg::port_west:  x = x + noc_route_pkg::coord_t'(1);
            noc_route_pkg::port_north: y = y + noc_route_pkg::coord_t'(1);
            noc_route_pkg::port_south: y = y - noc_route_pkg::coord_t'(1);
            default:                   x = next_r_addr_c[cw-1:0];
        endcase
        here_addr = {y, x};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            route_valid <= 1'b0;
            addr_error  <= 1'b0;
            destport    <= noc_route_pkg::port_local;
            lkdestport  <= noc_route_pkg::port_local;
        end else begin
            route_valid <= hdr_valid;           // one-cycle pulse per header
            if (hdr_valid) begin
                addr_error <= !addr_ok;
                destport   <= addr_ok ? destport_c : noc_route_pkg::port_local;
                lkdestport <= addr_ok ? lkdestport_c : noc_route_pkg::port_local;
            end
        end
    end

    // holds until the next strobe
    always_ff @(posedge clk) begin
        if (hdr_valid) begin
            next_r_addr <= addr_ok ? next_r_addr_c : here_addr;  // bad addr stays put
        end
    end

    a_next_in_mesh : assert property (@(posedge clk) disable iff (reset)
        route_valid && (destport != noc_route_pkg::port_local)
            |-> (int'(next_r_addr[cw-1:0]) < NX) && (int'(next_r_addr[aw-1:cw]) < NY));

    a_no_u_turn : assert property (@(posedge clk) disable iff (reset)
        !noc_route_pkg::is_reverse(destport, lkdestport));

endmodule

`default_nettype wire

// ==== mesh_xy_route.sv ====
`timescale 1ns/100ps
`default_nettype none

module mesh_xy_route #(
    parameter int NX = 4,   // columns, at most 8
    parameter int NY = 4    // rows, at most 8
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    hdr_valid,
    input  noc_route_pkg::r_addr_t  current_r_addr,
    input  noc_route_pkg::r_addr_t  dest_e_addr,
    output logic                    route_valid,
    output noc_route_pkg::port_e    destport,
    output noc_route_pkg::port_e    lkdestport,
    output noc_route_pkg::r_addr_t  next_r_addr,
    output logic                    addr_error
);

    logic                   addr_ok;
    noc_route_pkg::port_e   destport_c;
    noc_route_pkg::port_e   lkdestport_c;
    noc_route_pkg::r_addr_t next_r_addr_c;

    route_coord_if u_coord_if ();

    route_addr_decode #(
        .NX (NX),
        .NY (NY)
    ) u_route_addr_decode (
        .current_r_addr (current_r_addr),
        .dest_e_addr    (dest_e_addr),
        .coord          (u_coord_if.decode),
        .addr_ok        (addr_ok)
    );

    xy_route_execute u_xy_route_execute (
        .coord         (u_coord_if.execute),
        .destport_c    (destport_c),
        .lkdestport_c  (lkdestport_c),
        .next_r_addr_c (next_r_addr_c)
    );

    // single register stage, results one cycle after the strobe
    route_result_reg #(
        .NX (NX),
        .NY (NY)
    ) u_route_result_reg (
        .clk           (clk),
        .reset         (reset),
        .hdr_valid     (hdr_valid),
        .addr_ok       (addr_ok),
        .destport_c    (destport_c),
        .lkdestport_c  (lkdestport_c),
        .next_r_addr_c (next_r_addr_c),
        .route_valid   (route_valid),
        .addr_error    (addr_error),
        .destport      (destport),
        .lkdestport    (lkdestport),
        .next_r_addr   (next_r_addr)
    );

endmodule

`default_nettype wire

// ==== route_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

module route_checker #(
    parameter int NX         = 4,
    parameter int NY         = 4,
    parameter int max_cycles = 1200
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    hdr_valid,
    input  noc_route_pkg::r_addr_t  current_r_addr,
    input  noc_route_pkg::r_addr_t  dest_e_addr,
    input  logic                    route_valid,
    input  noc_route_pkg::port_e    destport,
    input  noc_route_pkg::port_e    lkdestport,
    input  noc_route_pkg::r_addr_t  next_r_addr,
    input  logic                    addr_error,
    input  logic [2:0]              test_id,
    input  logic                    run_done,
    output logic                    report_done,
    output logic                    timed_out,
    output int                      error_count
);

    localparam int         strobe_test = 4;
    localparam logic [2:0] idle_id     = 3'd7;

    // mesh port order
    localparam logic [2:0] p_local = 3'd0;
    localparam logic [2:0] p_east  = 3'd1;
    localparam logic [2:0] p_north = 3'd2;
    localparam logic [2:0] p_west  = 3'd3;
    localparam logic [2:0] p_south = 3'd4;

    int         checks [8];
    int         errs [8];
    int         cycles;
    int         strobes_in;
    int         strobes_out;
    int         tests_passed;
    int         tests_failed;
    logic       after_reset;
    logic       prev_valid;
    logic [2:0] prev_test;
    logic [5:0] prev_cur;
    logic [5:0] prev_dst;

    initial begin
        foreach (checks[i]) begin
            checks[i] = 0;
            errs[i]   = 0;
        end
        cycles       = 0;
        strobes_in   = 0;
        strobes_out  = 0;
        tests_passed = 0;
        tests_failed = 0;
        after_reset  = 1'b0;
        prev_valid   = 1'b0;
        prev_test    = idle_id;
        prev_cur     = '0;
        prev_dst     = '0;
        report_done  = 1'b0;
        timed_out    = 1'b0;
        error_count  = 0;
    end

    function automatic string test_name(input int t);
        case (t)
            0:       return "xy_random";
            1:       return "lookahead_random";
            2:       return "local_delivery";
            3:       return "bad_address";
            default: return "strobe_count";
        endcase
    endfunction

    // x first, then y; south is the growing y direction
    function automatic logic [2:0] model_port(input logic [2:0] cx, input logic [2:0] cy,
                                              input logic [2:0] dx, input logic [2:0] dy);
        if (dx > cx) return p_east;
        if (dx < cx) return p_west;
        if (dy > cy) return p_south;
        if (dy < cy) return p_north;
        return p_local;
    endfunction

    function automatic logic [5:0] model_step(input logic [5:0] a, input logic [2:0] p);
        logic [2:0] x;
        logic [2:0] y;
        x = a[2:0];
        y = a[5:3];
        case (p)
            p_east:  x = x + 3'd1;
            p_west:  x = x - 3'd1;
            p_north: y = y - 3'd1;
            p_south: y = y + 3'd1;
            default: x = a[2:0];
        endcase
        return {y, x};
    endfunction

    task automatic compare(input int t, input string what, input int expected,
                           input int actual);
        checks[t]++;
        if (expected != actual) begin
            errs[t]++;
            error_count++;
            $display("FAILED %s: %s expected %0d actual %0d",
                     test_name(t), what, expected, actual);
        end
    endtask

    task automatic check_item(input int t, input logic [5:0] cur, input logic [5:0] dst);
        logic       bad;
        logic [2:0] exp_dp;
        logic [2:0] exp_lk;
        logic [5:0] exp_next;
        bad = (int'(cur[2:0]) >= NX) || (int'(cur[5:3]) >= NY) ||
              (int'(dst[2:0]) >= NX) || (int'(dst[5:3]) >= NY);
        if (bad) begin
            exp_dp   = p_local;     // flit must not leave the router
            exp_lk   = p_local;
            exp_next = cur;
        end else begin
            exp_dp   = model_port(cur[2:0], cur[5:3], dst[2:0], dst[5:3]);
            exp_next = model_step(cur, exp_dp);
            exp_lk   = model_port(exp_next[2:0], exp_next[5:3], dst[2:0], dst[5:3]);
        end
        compare(t, "route_valid", 1, int'(route_valid));
        compare(t, "addr_error", int'(bad), int'(addr_error));
        compare(t, "destport", int'(exp_dp), int'(destport));
        compare(t, "lkdestport", int'(exp_lk), int'(lkdestport));
        compare(t, "next_r_addr", int'(exp_next), int'(next_r_addr));
    endtask

    task automatic report_test(input int t);
        if (errs[t] == 0) begin
            tests_passed++;
            $display("test %s ok, %0d checks", test_name(t), checks[t]);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches in %0d checks",
                     test_name(t), errs[t], checks[t]);
        end
    endtask

    // outputs here belong to the inputs seen one negedge earlier
    always @(negedge clk) begin
        cycles++;
        if (cycles >= max_cycles && !report_done) timed_out = 1'b1;
        if (reset) begin
            compare(strobe_test, "route_valid in reset", 0, int'(route_valid));
            compare(strobe_test, "addr_error in reset", 0, int'(addr_error));
            prev_valid  = 1'b0;
            prev_test   = idle_id;
            after_reset = 1'b1;
        end else begin
            if (after_reset) begin
                compare(strobe_test, "route_valid after reset", 0, int'(route_valid));
                compare(strobe_test, "addr_error after reset", 0, int'(addr_error));
                after_reset = 1'b0;
            end
            if (hdr_valid) strobes_in++;
            if (route_valid) strobes_out++;
            if (prev_valid) begin
                check_item(int'(prev_test), prev_cur, prev_dst);
            end else if (prev_test == idle_id) begin
                compare(strobe_test, "route_valid", 0, int'(route_valid));
            end else begin
                compare(int'(prev_test), "route_valid", 0, int'(route_valid));
            end
            if (prev_test != test_id && prev_test != idle_id) report_test(int'(prev_test));
            prev_valid = hdr_valid;
            prev_test  = test_id;
            prev_cur   = current_r_addr;
            prev_dst   = dest_e_addr;
            if (run_done && !report_done) begin
                compare(strobe_test, "route_valid count", strobes_in, strobes_out);
                report_test(strobe_test);
                $display("%0d tests passed, %0d tests failed, %0d mismatches",
                         tests_passed, tests_failed, error_count);
                report_done = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_top;

    localparam int NX = 4;
    localparam int NY = 4;
    localparam int cw = noc_route_pkg::coord_w;
    localparam int aw = noc_route_pkg::addr_w;

    localparam int reset_cycles = 16;
    localparam int n_xy         = 300;
    localparam int n_lookahead  = 300;
    localparam int n_local      = 50;
    localparam int n_bad        = 100;
    localparam int idle_cycles  = 4;    // drains the last result
    localparam int run_cycles   = reset_cycles + n_xy + n_lookahead + n_local + n_bad
                                  + idle_cycles;
    localparam int max_cycles   = run_cycles + run_cycles / 2;

    logic                   clk;
    logic                   reset;
    logic                   hdr_valid;
    noc_route_pkg::r_addr_t current_r_addr;
    noc_route_pkg::r_addr_t dest_e_addr;
    logic                   route_valid;
    noc_route_pkg::port_e   destport;
    noc_route_pkg::port_e   lkdestport;
    noc_route_pkg::r_addr_t next_r_addr;
    logic                   addr_error;

    logic [2:0]  test_id;
    logic        run_done;
    logic        report_done;
    logic        timed_out;
    int          error_count;
    logic [15:0] lfsr_state;

    mesh_xy_route #(
        .NX (NX),
        .NY (NY)
    ) u_mesh_xy_route (
        .clk            (clk),
        .reset          (reset),
        .hdr_valid      (hdr_valid),
        .current_r_addr (current_r_addr),
        .dest_e_addr    (dest_e_addr),
        .route_valid    (route_valid),
        .destport       (destport),
        .lkdestport     (lkdestport),
        .next_r_addr    (next_r_addr),
        .addr_error     (addr_error)
    );

    route_checker #(
        .NX         (NX),
        .NY         (NY),
        .max_cycles (max_cycles)
    ) u_route_checker (
        .clk            (clk),
        .reset          (reset),
        .hdr_valid      (hdr_valid),
        .current_r_addr (current_r_addr),
        .dest_e_addr    (dest_e_addr),
        .route_valid    (route_valid),
        .destport       (destport),
        .lkdestport     (lkdestport),
        .next_r_addr    (next_r_addr),
        .addr_error     (addr_error),
        .test_id        (test_id),
        .run_done       (run_done),
        .report_done    (report_done),
        .timed_out      (timed_out),
        .error_count    (error_count)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;     // 100 ns period
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [7:0] value);
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[6:0], lfsr_state[0]};   // one step per bit
        end
    endtask

    task automatic rand_coord(input int limit, output noc_route_pkg::coord_t c);
        logic [7:0] bits;
        take_bits(cw, bits);
        c = noc_route_pkg::coord_t'(int'(bits) % limit);
    endtask

    // coordinate between limit and the top of the field
    task automatic bad_coord(input int limit, output noc_route_pkg::coord_t c);
        logic [7:0] bits;
        take_bits(cw, bits);
        c = noc_route_pkg::coord_t'(limit + int'(bits) % ((1 << cw) - limit));
    endtask

    task automatic rand_addr(output noc_route_pkg::r_addr_t a);
        noc_route_pkg::coord_t x;
        noc_route_pkg::coord_t y;
        rand_coord(NX, x);
        rand_coord(NY, y);
        a = {y, x};
    endtask

    task automatic bad_pair(output noc_route_pkg::r_addr_t cur,
                            output noc_route_pkg::r_addr_t dst);
        logic [7:0]            pick;
        noc_route_pkg::coord_t c;
        rand_addr(cur);
        rand_addr(dst);
        take_bits(2, pick);
        case (pick[1:0])    // spoil one of the four fields
            2'd0: begin
                bad_coord(NX, c);
                cur[cw-1:0] = c;
            end
            2'd1: begin
                bad_coord(NY, c);
                cur[aw-1:cw] = c;
            end
            2'd2: begin
                bad_coord(NX, c);
                dst[cw-1:0] = c;
            end
            default: begin
                bad_coord(NY, c);
                dst[aw-1:cw] = c;
            end
        endcase
    endtask

    task automatic drive(input logic [2:0] id, input logic v,
                         input noc_route_pkg::r_addr_t cur,
                         input noc_route_pkg::r_addr_t dst);
        @(posedge clk);
        #10;
        test_id        = id;
        hdr_valid      = v;
        current_r_addr = cur;
        dest_e_addr    = dst;
    endtask

    initial begin
        noc_route_pkg::r_addr_t cur;
        noc_route_pkg::r_addr_t dst;
        logic [7:0]             strobe;
        reset          = 1'b1;
        hdr_valid      = 1'b0;
        current_r_addr = '0;
        dest_e_addr    = '0;
        test_id        = 3'd7;
        run_done       = 1'b0;
        lfsr_state     = 16'd10564;
        repeat (reset_cycles) @(posedge clk);
        #10;
        reset = 1'b0;

        for (int i = 0; i < n_xy; i++) begin
            rand_addr(cur);
            rand_addr(dst);
            drive(3'd0, 1'b1, cur, dst);    // back to back headers
        end
        for (int i = 0; i < n_lookahead; i++) begin
            rand_addr(cur);
            rand_addr(dst);
            take_bits(1, strobe);
            drive(3'd1, strobe[0], cur, dst);
        end
        for (int i = 0; i < n_local; i++) begin
            rand_addr(cur);
            drive(3'd2, 1'b1, cur, cur);
        end
        for (int i = 0; i < n_bad; i++) begin
            bad_pair(cur, dst);
            drive(3'd3, 1'b1, cur, dst);
        end
        repeat (idle_cycles) drive(3'd7, 1'b0, '0, '0);
        run_done = 1'b1;
    end

    initial begin
        @(posedge clk);
        while (!report_done && !timed_out) @(posedge clk);
        if (timed_out) begin
            $display("run did not finish within %0d cycles", max_cycles);
        end
        if (!timed_out && error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
noc_route_pkg.sv
route_coord_if.sv
route_addr_decode.sv
xy_route_execute.sv
route_result_reg.sv
mesh_xy_route.sv
route_checker.sv
tb_top.sv

// ==== Makefile ====
# Verilator build and run for the mesh XY routing testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

SOURCES := $(shell cat $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM) | tee $(LOG)
	@grep -q "^Regression passed$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
